// File: logic/eth_pkg.sv
package eth_pkg;

	//////////////////////////////////////////////////////////////
	// GMII byte lane

	// One data byte per clock on rxd/txd
	typedef logic [7:0] gmii_byte_t;

	//////////////////////////////////////////////////////////////
	// Speed codes

	// Same encoding as the PHY speed status bits
	// Code 3 is reserved and never reported
	typedef enum logic [1:0] {
		SPEED_10   = 2'd0,
		SPEED_100  = 2'd1,
		SPEED_1000 = 2'd2
	} speed_t;

endpackage

// File: logic/ft_pkg.sv
package ft_pkg;

	//////////////////////////////////////////////////////////////
	// Redundant port set

	// Two PHYs, one of them carries traffic at a time
	localparam int unsigned PHY_PORT_NUM = 2;

	// Index of the active PHY port
	typedef logic [$clog2(PHY_PORT_NUM)-1:0] port_idx_t;

	//////////////////////////////////////////////////////////////
	// Link qualification

	// Cycles the raw link level must stay high before it counts,
	// long enough to ride out autonegotiation bounces
	localparam int unsigned DEFAULT_LINK_HOLD = 16;

endpackage

// File: logic/gmii_if.sv
`timescale 1ns/100ps

// One GMII lane in one direction
interface gmii_if;

	// Byte data
	eth_pkg::gmii_byte_t data;
	// rx_dv on receive, tx_en on transmit
	logic valid;
	// rx_er or tx_er
	logic err;
	// Carrier sense and collision, receive lanes only
	logic crs;
	logic col;

	// Consumer side of the lane
	modport mac (
		input data,
		input valid,
		input err,
		input crs,
		input col
	);

	// Producer side of the lane
	modport phy (
		output data,
		output valid,
		output err,
		output crs,
		output col
	);

endinterface

// File: logic/link_qualifier.sv
`timescale 1ns/100ps

module link_qualifier #(
	parameter int unsigned LINK_HOLD_CYCLES = ft_pkg::DEFAULT_LINK_HOLD
) (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            raw_up_i,
	input  eth_pkg::speed_t raw_speed_i,
	output logic            up_o,
	output eth_pkg::speed_t speed_o
);

	// Count to HOLD-1, the qualifying sample is the one after that
	localparam int unsigned CNT_W = (LINK_HOLD_CYCLES > 1) ? $clog2(LINK_HOLD_CYCLES) : 1;
	localparam logic [CNT_W-1:0] HOLD_MAX = CNT_W'(LINK_HOLD_CYCLES - 1);

	logic [CNT_W-1:0] hold_cnt;
	logic             hold_done;
	logic             up_q;
	eth_pkg::speed_t  speed_q;

	assign hold_done = (hold_cnt == HOLD_MAX);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hold_cnt <= '0;
			up_q     <= 1'b0;
			speed_q  <= eth_pkg::SPEED_10;
		end else if (!raw_up_i) begin
			// Any low sample restarts the hold time
			hold_cnt <= '0;
			up_q     <= 1'b0;
		end else begin
			// Saturate once the hold value is reached
			if (!hold_done) begin
				hold_cnt <= hold_cnt + 1'b1;
			end
			// Speed is only trusted once the link has settled
			if (hold_done && !up_q) begin
				up_q    <= 1'b1;
				speed_q <= raw_speed_i;
			end
		end
	end

	assign up_o    = up_q;
	assign speed_o = speed_q;

endmodule

// File: logic/failover_ctrl.sv
`timescale 1ns/100ps

module failover_ctrl (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               up_i [ft_pkg::PHY_PORT_NUM],
	input  eth_pkg::speed_t    speed_i [ft_pkg::PHY_PORT_NUM],
	input  logic               mac_tx_busy_i,
	input  logic               phy_rx_busy_i [ft_pkg::PHY_PORT_NUM],
	output ft_pkg::port_idx_t  active_port_o,
	output logic               link_up_o,
	output eth_pkg::speed_t    speed_o,
	output logic               link_change_o
);

	ft_pkg::port_idx_t active_q;
	ft_pkg::port_idx_t standby;
	ft_pkg::port_idx_t active_nxt;
	logic              medium_idle;
	logic              switch_ok;
	logic              link_up_nxt;
	eth_pkg::speed_t   speed_nxt;
	logic              link_up_q;
	eth_pkg::speed_t   speed_q;
	logic              link_change_q;

	////////////////////////////////////////////////////////////
	// Switch decision

	always_comb begin
		standby = ~active_q;
		// No frame in flight in either direction on the active port
		medium_idle = !mac_tx_busy_i && !phy_rx_busy_i[active_q];
		// Only move away from a dead link, and only onto a live one
		switch_ok   = !up_i[active_q] && up_i[standby] && medium_idle;
		active_nxt  = switch_ok ? standby : active_q;
		// Report the port that will be active after this edge
		link_up_nxt = up_i[active_nxt];
		speed_nxt   = speed_i[active_nxt];
	end

	////////////////////////////////////////////////////////////
	// Registered state and reporting

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			active_q      <= '0;
			link_up_q     <= 1'b0;
			speed_q       <= eth_pkg::SPEED_10;
			link_change_q <= 1'b0;
		end else begin
			// No switch back, the new port stays until it fails itself
			active_q      <= active_nxt;
			link_up_q     <= link_up_nxt;
			speed_q       <= speed_nxt;
			// Pulse together with the new reported values
			link_change_q <= (link_up_nxt != link_up_q) || switch_ok;
		end
	end

	assign active_port_o = active_q;
	assign link_up_o     = link_up_q;
	assign speed_o       = speed_q;
	assign link_change_o = link_change_q;

endmodule

// File: logic/gmii_crossbar.sv
`timescale 1ns/100ps

module gmii_crossbar (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  ft_pkg::port_idx_t   active_port_i,
	gmii_if.mac                 phy0_rx,
	gmii_if.mac                 phy1_rx,
	gmii_if.phy                 mac_rx,
	gmii_if.mac                 mac_tx,
	output eth_pkg::gmii_byte_t phy0_txd_o,
	output eth_pkg::gmii_byte_t phy1_txd_o,
	output logic                phy0_txen_o,
	output logic                phy1_txen_o,
	output logic                phy0_txer_o,
	output logic                phy1_txer_o
);

	// High while port 0 is the active one
	logic sel0;

	assign sel0 = (active_port_i == ft_pkg::port_idx_t'(0));

	////////////////////////////////////////////////////////////
	// Receive, active PHY to MAC

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mac_rx.data  <= '0;
			mac_rx.valid <= 1'b0;
			mac_rx.err   <= 1'b0;
			mac_rx.crs   <= 1'b0;
			mac_rx.col   <= 1'b0;
		end else if (sel0) begin
			mac_rx.data  <= phy0_rx.data;
			mac_rx.valid <= phy0_rx.valid;
			mac_rx.err   <= phy0_rx.err;
			mac_rx.crs   <= phy0_rx.crs;
			mac_rx.col   <= phy0_rx.col;
		end else begin
			mac_rx.data  <= phy1_rx.data;
			mac_rx.valid <= phy1_rx.valid;
			mac_rx.err   <= phy1_rx.err;
			mac_rx.crs   <= phy1_rx.crs;
			mac_rx.col   <= phy1_rx.col;
		end
	end

	////////////////////////////////////////////////////////////
	// Transmit, MAC to active PHY only

	// Standby PHY sees an idle lane, all zeros
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			phy0_txd_o  <= '0;
			phy0_txen_o <= 1'b0;
			phy0_txer_o <= 1'b0;
			phy1_txd_o  <= '0;
			phy1_txen_o <= 1'b0;
			phy1_txer_o <= 1'b0;
		end else begin
			phy0_txd_o  <= sel0 ? mac_tx.data : '0;
			phy0_txen_o <= sel0 & mac_tx.valid;
			phy0_txer_o <= sel0 & mac_tx.err;
			phy1_txd_o  <= sel0 ? '0 : mac_tx.data;
			phy1_txen_o <= ~sel0 & mac_tx.valid;
			phy1_txer_o <= ~sel0 & mac_tx.err;
		end
	end

endmodule

// File: logic/phy_ft_top.sv
`timescale 1ns/100ps

module phy_ft_top #(
	parameter int unsigned LINK_HOLD_CYCLES = ft_pkg::DEFAULT_LINK_HOLD
) (
	input  logic                clk_i,
	input  logic                rst_n_i,

	// PHY port 0
	input  eth_pkg::gmii_byte_t p0_rxd_i,
	input  logic                p0_rxdv_i,
	input  logic                p0_rxer_i,
	input  logic                p0_crs_i,
	input  logic                p0_col_i,
	input  logic                p0_up_i,
	input  eth_pkg::speed_t     p0_speed_i,
	output eth_pkg::gmii_byte_t p0_txd_o,
	output logic                p0_txen_o,
	output logic                p0_txer_o,

	// PHY port 1
	input  eth_pkg::gmii_byte_t p1_rxd_i,
	input  logic                p1_rxdv_i,
	input  logic                p1_rxer_i,
	input  logic                p1_crs_i,
	input  logic                p1_col_i,
	input  logic                p1_up_i,
	input  eth_pkg::speed_t     p1_speed_i,
	output eth_pkg::gmii_byte_t p1_txd_o,
	output logic                p1_txen_o,
	output logic                p1_txer_o,

	// MAC side
	input  eth_pkg::gmii_byte_t mac_txd_i,
	input  logic                mac_txen_i,
	input  logic                mac_txer_i,
	output eth_pkg::gmii_byte_t mac_rxd_o,
	output logic                mac_rxdv_o,
	output logic                mac_rxer_o,
	output logic                mac_crs_o,
	output logic                mac_col_o,

	// Link status towards the MAC
	output ft_pkg::port_idx_t   active_port_o,
	output logic                link_up_o,
	output eth_pkg::speed_t     speed_o,
	output logic                link_change_o
);

	logic            qual_up [ft_pkg::PHY_PORT_NUM];
	eth_pkg::speed_t qual_speed [ft_pkg::PHY_PORT_NUM];
	logic            rx_busy [ft_pkg::PHY_PORT_NUM];

	gmii_if phy0_rx_if ();
	gmii_if phy1_rx_if ();
	gmii_if mac_rx_if ();
	gmii_if mac_tx_if ();

	////////////////////////////////////////////////////////////
	// Bundle the plain ports

	assign phy0_rx_if.data  = p0_rxd_i;
	assign phy0_rx_if.valid = p0_rxdv_i;
	assign phy0_rx_if.err   = p0_rxer_i;
	assign phy0_rx_if.crs   = p0_crs_i;
	assign phy0_rx_if.col   = p0_col_i;

	assign phy1_rx_if.data  = p1_rxd_i;
	assign phy1_rx_if.valid = p1_rxdv_i;
	assign phy1_rx_if.err   = p1_rxer_i;
	assign phy1_rx_if.crs   = p1_crs_i;
	assign phy1_rx_if.col   = p1_col_i;

	assign mac_tx_if.data  = mac_txd_i;
	assign mac_tx_if.valid = mac_txen_i;
	assign mac_tx_if.err   = mac_txer_i;
	// No carrier or collision on the transmit lane
	assign mac_tx_if.crs   = 1'b0;
	assign mac_tx_if.col   = 1'b0;

	assign mac_rxd_o  = mac_rx_if.data;
	assign mac_rxdv_o = mac_rx_if.valid;
	assign mac_rxer_o = mac_rx_if.err;
	assign mac_crs_o  = mac_rx_if.crs;
	assign mac_col_o  = mac_rx_if.col;

	assign rx_busy[0] = p0_rxdv_i;
	assign rx_busy[1] = p1_rxdv_i;

	////////////////////////////////////////////////////////////
	// Link qualification per PHY

	link_qualifier #(.LINK_HOLD_CYCLES(LINK_HOLD_CYCLES)) i_link_qualifier_0 (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.raw_up_i   (p0_up_i),
		.raw_speed_i(p0_speed_i),
		.up_o       (qual_up[0]),
		.speed_o    (qual_speed[0])
	);

	link_qualifier #(.LINK_HOLD_CYCLES(LINK_HOLD_CYCLES)) i_link_qualifier_1 (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.raw_up_i   (p1_up_i),
		.raw_speed_i(p1_speed_i),
		.up_o       (qual_up[1]),
		.speed_o    (qual_speed[1])
	);

	////////////////////////////////////////////////////////////
	// Port choice and data path

	failover_ctrl i_failover_ctrl (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.up_i         (qual_up),
		.speed_i      (qual_speed),
		.mac_tx_busy_i(mac_txen_i),
		.phy_rx_busy_i(rx_busy),
		.active_port_o(active_port_o),
		.link_up_o    (link_up_o),
		.speed_o      (speed_o),
		.link_change_o(link_change_o)
	);

	gmii_crossbar i_gmii_crossbar (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.active_port_i(active_port_o),
		.phy0_rx      (phy0_rx_if.mac),
		.phy1_rx      (phy1_rx_if.mac),
		.mac_rx       (mac_rx_if.phy),
		.mac_tx       (mac_tx_if.mac),
		.phy0_txd_o   (p0_txd_o),
		.phy1_txd_o   (p1_txd_o),
		.phy0_txen_o  (p0_txen_o),
		.phy1_txen_o  (p1_txen_o),
		.phy0_txer_o  (p0_txer_o),
		.phy1_txer_o  (p1_txer_o)
	);

endmodule

// File: tb/phy_ft_assertions.sv
`timescale 1ns/100ps

module phy_ft_assertions (
	input logic                clk_i,
	input logic                rst_n_i,
	input ft_pkg::port_idx_t   active_port_i,
	input logic                mac_txen_i,
	input logic                p0_rxdv_i,
	input logic                p1_rxdv_i,
	input eth_pkg::gmii_byte_t p0_txd_i,
	input logic                p0_txen_i,
	input logic                p0_txer_i,
	input eth_pkg::gmii_byte_t p1_txd_i,
	input logic                p1_txen_i,
	input logic                p1_txer_i,
	input logic                link_change_i
);

	// Failed assertion count
	int unsigned fail_count = 0;

	logic busy;

	// Frame in flight on the active port, either direction
	assign busy = mac_txen_i || ((active_port_i == 0) ? p0_rxdv_i : p1_rxdv_i);

	switch_only_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		busy |=> $stable(active_port_i)
	) else begin
		$error("active port changed while a frame was in flight");
		fail_count++;
	end

	// Transmit lanes follow the port that was active one edge earlier
	p1_tx_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		($past(active_port_i) == 0) |-> (p1_txd_i == 0 && !p1_txen_i && !p1_txer_i)
	) else begin
		$error("standby port 1 transmit lane is not idle");
		fail_count++;
	end

	p0_tx_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		($past(active_port_i) == 1) |-> (p0_txd_i == 0 && !p0_txen_i && !p0_txer_i)
	) else begin
		$error("standby port 0 transmit lane is not idle");
		fail_count++;
	end

	change_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		link_change_i |=> !link_change_i
	) else begin
		$error("link change pulse lasted more than one cycle");
		fail_count++;
	end

endmodule

bind phy_ft_top phy_ft_assertions i_phy_ft_assertions (
	.clk_i        (clk_i),
	.rst_n_i      (rst_n_i),
	.active_port_i(active_port_o),
	.mac_txen_i   (mac_txen_i),
	.p0_rxdv_i    (p0_rxdv_i),
	.p1_rxdv_i    (p1_rxdv_i),
	.p0_txd_i     (p0_txd_o),
	.p0_txen_i    (p0_txen_o),
	.p0_txer_i    (p0_txer_o),
	.p1_txd_i     (p1_txd_o),
	.p1_txen_i    (p1_txen_o),
	.p1_txer_i    (p1_txer_o),
	.link_change_i(link_change_o)
);

// File: tb/tb_phy_ft.sv
`timescale 1ns/100ps

module tb_phy_ft;

	localparam int unsigned HOLD      = 8;
	localparam int unsigned FIELDS    = 11;
	localparam int unsigned MAX_STEPS = 32;
	localparam int unsigned RESET_CYC = 5;
	localparam int unsigned MARGIN    = 50;

	logic                clk_i = 1'b0;
	logic                rst_n_i;
	eth_pkg::gmii_byte_t p0_rxd_i;
	logic                p0_rxdv_i;
	logic                p0_rxer_i;
	logic                p0_crs_i;
	logic                p0_col_i;
	logic                p0_up_i;
	eth_pkg::speed_t     p0_speed_i;
	eth_pkg::gmii_byte_t p0_txd_o;
	logic                p0_txen_o;
	logic                p0_txer_o;
	eth_pkg::gmii_byte_t p1_rxd_i;
	logic                p1_rxdv_i;
	logic                p1_rxer_i;
	logic                p1_crs_i;
	logic                p1_col_i;
	logic                p1_up_i;
	eth_pkg::speed_t     p1_speed_i;
	eth_pkg::gmii_byte_t p1_txd_o;
	logic                p1_txen_o;
	logic                p1_txer_o;
	eth_pkg::gmii_byte_t mac_txd_i;
	logic                mac_txen_i;
	logic                mac_txer_i;
	eth_pkg::gmii_byte_t mac_rxd_o;
	logic                mac_rxdv_o;
	logic                mac_rxer_o;
	logic                mac_crs_o;
	logic                mac_col_o;
	ft_pkg::port_idx_t   active_port_o;
	logic                link_up_o;
	eth_pkg::speed_t     speed_o;
	logic                link_change_o;

	// Fields per step are p0 up, p0 speed, p1 up, p1 speed, txen, rxdv and cycles
	// followed by expected active, link up, speed and pulse count
	logic [7:0]  stim [FIELDS*MAX_STEPS];
	logic [31:0] rng_state = 32'hb421_c400;
	// Last driven random word and levels
	logic [31:0] cur_rand = '0;
	logic        cur_txen = 1'b0;
	logic        cur_rxdv0 = 1'b0;
	logic        cur_rxdv1 = 1'b0;
	// Receive frame level of the step and the port active when it started
	logic        frame_rxdv = 1'b0;
	logic        frame_port = 1'b0;
	// Copies of what the DUT sampled on the last edge
	logic [31:0] seen_rand = '0;
	logic        seen_txen = 1'b0;
	logic        seen_rxdv0 = 1'b0;
	logic        seen_rxdv1 = 1'b0;
	int unsigned num_steps;
	int unsigned cycle_limit;
	int unsigned cycle_count;
	int unsigned error_count;
	int unsigned check_count;

	phy_ft_top #(.LINK_HOLD_CYCLES(HOLD)) i_phy_ft_top (.*);

	always #4 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("ERROR: timeout, the run went past %0d clock cycles", cycle_limit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("MISMATCH %s: expected 'h%0h, got 'h%0h at %0t",
				name, expected, actual, $time);
		end
	endtask

	task automatic apply_levels(input int unsigned base, input logic port);
		p0_up_i    <= stim[base][0];
		p0_speed_i <= eth_pkg::speed_t'(stim[base+1][1:0]);
		p1_up_i    <= stim[base+2][0];
		p1_speed_i <= eth_pkg::speed_t'(stim[base+3][1:0]);
		mac_txen_i <= stim[base+4][0];
		cur_txen   = stim[base+4][0];
		frame_rxdv = stim[base+5][0];
		frame_port = port;
	endtask

	// Fresh bytes and side bits on every lane
	task automatic drive_bytes();
		rng_state = next_rand(rng_state);
		cur_rand  = rng_state;
		// Stray frames on the standby PHY must not hold off a switch
		cur_rxdv0 = frame_rxdv | (frame_port & cur_rand[31]);
		cur_rxdv1 = frame_rxdv | (!frame_port & cur_rand[31]);
		p0_rxd_i   <= cur_rand[7:0];
		p1_rxd_i   <= cur_rand[15:8];
		mac_txd_i  <= cur_rand[23:16];
		p0_rxdv_i  <= cur_rxdv0;
		p1_rxdv_i  <= cur_rxdv1;
		p0_rxer_i  <= cur_rand[24];
		p1_rxer_i  <= cur_rand[25];
		p0_crs_i   <= cur_rand[26];
		p1_crs_i   <= cur_rand[27];
		p0_col_i   <= cur_rand[28];
		p1_col_i   <= cur_rand[29];
		mac_txer_i <= cur_rand[30];
	endtask

	// Outputs lag the sampled inputs by one cycle and follow the active PHY
	task automatic check_routing(input logic active);
		logic [7:0] tx_byte;
		tx_byte = seen_rand[23:16];
		check_value("mac_rxd_o", active ? seen_rand[15:8] : seen_rand[7:0], mac_rxd_o);
		check_value("mac_rxdv_o", active ? seen_rxdv1 : seen_rxdv0, mac_rxdv_o);
		check_value("mac_rxer_o", seen_rand[24+active], mac_rxer_o);
		check_value("mac_crs_o", seen_rand[26+active], mac_crs_o);
		check_value("mac_col_o", seen_rand[28+active], mac_col_o);
		check_value("p0_txd_o", active ? 8'h00 : tx_byte, p0_txd_o);
		check_value("p0_txen_o", !active && seen_txen, p0_txen_o);
		check_value("p0_txer_o", !active && seen_rand[30], p0_txer_o);
		check_value("p1_txd_o", active ? tx_byte : 8'h00, p1_txd_o);
		check_value("p1_txen_o", active && seen_txen, p1_txen_o);
		check_value("p1_txer_o", active && seen_rand[30], p1_txer_o);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int unsigned base;
		int unsigned pulses;
		int unsigned total;
		int unsigned assert_fails;
		logic [7:0]  cycles;
		logic        prev_active;
		logic        route_on;

		rst_n_i    = 1'b0;
		p0_rxd_i   = '0;
		p0_rxdv_i  = 1'b0;
		p0_rxer_i  = 1'b0;
		p0_crs_i   = 1'b0;
		p0_col_i   = 1'b0;
		p0_up_i    = 1'b0;
		p0_speed_i = eth_pkg::SPEED_10;
		p1_rxd_i   = '0;
		p1_rxdv_i  = 1'b0;
		p1_rxer_i  = 1'b0;
		p1_crs_i   = 1'b0;
		p1_col_i   = 1'b0;
		p1_up_i    = 1'b0;
		p1_speed_i = eth_pkg::SPEED_10;
		mac_txd_i  = '0;
		mac_txen_i = 1'b0;
		mac_txer_i = 1'b0;

		$readmemh("tb/phy_ft_stimulus.txt", stim);
		total     = 0;
		num_steps = 0;
		while (num_steps < MAX_STEPS) begin
			cycles = stim[num_steps*FIELDS+6];
			if ($isunknown(cycles) || cycles == 0) begin
				break;
			end
			total += cycles;
			num_steps++;
		end
		if (num_steps == 0) begin
			$display("ERROR: no steps were read from tb/phy_ft_stimulus.txt");
			error_count++;
		end
		cycle_limit = RESET_CYC + 2 + total + MARGIN;

		// Reset values are visible while reset is still low
		repeat (RESET_CYC - 1) @(posedge clk_i);
		@(negedge clk_i);
		check_routing(1'b0);
		check_value("active_port_o", 0, active_port_o);
		check_value("link_up_o", 0, link_up_o);
		check_value("speed_o", 0, speed_o);
		check_value("link_change_o", 0, link_change_o);
		@(posedge clk_i);
		rst_n_i <= 1'b1;
		@(posedge clk_i);
		if (num_steps > 0) begin
			apply_levels(0, 1'b0);
		end
		drive_bytes();

		prev_active = 1'b0;
		for (int unsigned k = 0; k < num_steps; k++) begin
			base   = k * FIELDS;
			pulses = 0;
			// Routing is only predictable while the port stays put
			route_on = (stim[base+7][0] == prev_active);
			for (int unsigned i = 0; i < stim[base+6]; i++) begin
				@(posedge clk_i);
				seen_rand  = cur_rand;
				seen_txen  = cur_txen;
				seen_rxdv0 = cur_rxdv0;
				seen_rxdv1 = cur_rxdv1;
				// Next step takes over on the last edge of this one
				if (i == stim[base+6] - 1 && k + 1 < num_steps) begin
					apply_levels(base + FIELDS, stim[base+7][0]);
				end
				drive_bytes();
				@(negedge clk_i);
				if (route_on) begin
					check_routing(stim[base+7][0]);
				end
				if (link_change_o) begin
					pulses++;
				end
			end
			check_value("active_port_o", stim[base+7], active_port_o);
			check_value("link_up_o", stim[base+8], link_up_o);
			check_value("speed_o", stim[base+9], speed_o);
			check_value("link_change_o pulses", stim[base+10], pulses);
			prev_active = stim[base+7][0];
		end

		assert_fails = i_phy_ft_top.i_phy_ft_assertions.fail_count;
		$display("Summary: %0d steps, %0d checks, %0d mismatches, %0d assertion failures",
			num_steps, check_count, error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: tb/phy_ft_stimulus.txt
// p0_up p0_spd p1_up p1_spd txen rxdv cycles | exp_active exp_up exp_spd exp_pulses
// All hex, rxdv goes to both PHYs, a step with zero cycles ends the table
// Idle after reset
0 0 0 0 0 0 04  0 0 0 0
// Port 0 bounces for less than the hold time, then drops
1 2 0 0 0 0 05  0 0 0 0
0 2 0 0 0 0 02  0 0 0 0
// Port 0 qualifies at 1000, reported two cycles after the hold
1 2 0 0 0 0 08  0 0 0 0
1 2 0 0 0 0 02  0 1 2 1
// Traffic through port 0
1 2 0 0 1 1 10  0 1 2 0
// Port 1 qualifies at 100 as standby
1 2 1 1 0 0 0a  0 1 2 0
// Port 0 lost while idle, switch to port 1
0 2 1 1 0 0 04  1 1 1 1
// Port 0 back, no switch back, traffic on port 1
1 2 1 1 1 1 0c  1 1 1 0
// Port 1 lost during a transmit frame, switch waits
1 2 0 1 1 0 06  1 0 1 1
1 2 0 1 0 0 04  0 1 2 1
// Port 1 back at 10 as standby
1 2 1 0 0 0 0a  0 1 2 0
// Port 0 lost during a receive frame, switch waits
0 2 1 0 0 1 04  0 0 2 1
0 2 1 0 0 0 04  1 1 0 1
// Both links down
0 2 0 0 0 0 06  1 0 0 1
0 2 0 0 1 1 08  1 0 0 0
// End of table
0 0 0 0 0 0 00  0 0 0 0

// File: sim.f
logic/eth_pkg.sv
logic/ft_pkg.sv
logic/gmii_if.sv
logic/link_qualifier.sv
logic/failover_ctrl.sv
logic/gmii_crossbar.sv
logic/phy_ft_top.sv
tb/phy_ft_assertions.sv
tb/tb_phy_ft.sv

// File: Bender.yml
package:
  name: phy_ft

sources:
  - logic/eth_pkg.sv
  - logic/ft_pkg.sv
  - logic/gmii_if.sv
  - logic/link_qualifier.sv
  - logic/failover_ctrl.sv
  - logic/gmii_crossbar.sv
  - logic/phy_ft_top.sv
  - target: simulation
    files:
      - tb/phy_ft_assertions.sv
      - tb/tb_phy_ft.sv
